// ==== rtl/radio_pkg.sv ====
// Shared definitions for the radio control plane.
// Holds the setting addresses, bus widths, readback slots and the command,
// settings bus and readback types that every block and the testbench import.
package radio_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int TIME_W     = 64;
   localparam int RB_SEL_W   = 3;
   localparam int MISC_W     = 8;
   localparam int SAMPLE_W   = 32;
   localparam int CMD_W      = 64;
   localparam int RB_W       = 64;
   localparam int OP_W       = 2;

   // Bits of the command word left between opcode and address
   localparam int CMD_SPARE_W = CMD_W - OP_W - SET_ADDR_W - SET_DATA_W;

   //////////////////////////////
   // Setting addresses
   //////////////////////////////
   localparam logic [SET_ADDR_W-1:0] SR_DACSYNC    = 8'd5;
   localparam logic [SET_ADDR_W-1:0] SR_LOOPBACK   = 8'd6;
   localparam logic [SET_ADDR_W-1:0] SR_TEST       = 8'd7;
   localparam logic [SET_ADDR_W-1:0] SR_MISC_OUTS  = 8'd24;
   localparam logic [SET_ADDR_W-1:0] SR_READBACK   = 8'd32;
   localparam logic [SET_ADDR_W-1:0] SR_TIME       = 8'd128;
   localparam logic [SET_ADDR_W-1:0] SR_CODEC_IDLE = 8'd250;

   // Timekeeper block of four addresses from SR_TIME
   localparam logic [SET_ADDR_W-1:0] SR_TIME_HI  = SR_TIME + 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_LO  = SR_TIME + 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_NOW = SR_TIME + 8'd2;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_PPS = SR_TIME + 8'd3;

   //////////////////////////////
   // Types
   //////////////////////////////
   typedef enum logic [OP_W-1:0] {
      OP_WRITE = 2'd0,
      OP_READ  = 2'd1
   } cmd_op_e;

   // Slots 0 and 4 are kept as zero words and 7 falls to the default
   typedef enum logic [RB_SEL_W-1:0] {
      RB_NONE      = 3'd0,
      RB_TIME      = 3'd1,
      RB_LASTPPS   = 3'd2,
      RB_RX_TEST   = 3'd3,
      RB_ZERO      = 3'd4,
      RB_TX_RX     = 3'd5,
      RB_RADIO_NUM = 3'd6
   } rb_slot_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SET,
      ST_CAPTURE,
      ST_RESP
   } ctrl_state_e;

   typedef struct packed {
      cmd_op_e                opcode;
      logic [CMD_SPARE_W-1:0] spare;
      logic [SET_ADDR_W-1:0]  addr;
      logic [SET_DATA_W-1:0]  data;
   } cmd_t;

   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   typedef logic [RB_W-1:0] rb_word_t;

endpackage

// ==== rtl/radio_ctrl_fsm.sv ====
// Command sequencer for the radio control plane.
// Takes one command word per accepted strobe, drives the settings bus for a
// write, then times the readback capture and the response strobe.
`timescale 1ns/1ps

module radio_ctrl_fsm
   import radio_pkg::*;
(
   input  logic     i_radio_clk,
   input  logic     i_rst,
   input  logic     i_cmd_stb,
   input  cmd_t     i_cmd,
   output set_bus_t o_set,
   output logic     o_capture,
   output logic     o_busy,
   output logic     o_resp_stb
);

   ctrl_state_e           state;
   cmd_op_e               op_q;
   logic [SET_ADDR_W-1:0] addr_q;
   logic [SET_DATA_W-1:0] data_q;
   logic                  set_stb_q;
   logic                  cmd_accept;

   // Anything outside idle counts as busy
   assign o_busy     = (state != ST_IDLE);
   assign cmd_accept = i_cmd_stb && !o_busy;

   //////////////////////////////
   // Sequencer
   //////////////////////////////
   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         state      <= ST_IDLE;
         set_stb_q  <= 1'b0;
         o_capture  <= 1'b0;
         o_resp_stb <= 1'b0;
      end else begin
         // Strobes last a single cycle
         set_stb_q  <= 1'b0;
         o_capture  <= 1'b0;
         o_resp_stb <= 1'b0;

         case (state)
            ST_IDLE: begin
               if (cmd_accept) begin
                  state <= ST_SET;
               end
            end
            ST_SET: begin
               // Reads leave the settings bus quiet
               set_stb_q <= (op_q == OP_WRITE);
               state     <= ST_CAPTURE;
            end
            ST_CAPTURE: begin
               // Register load lands on this edge and capture follows it
               o_capture <= 1'b1;
               state     <= ST_RESP;
            end
            ST_RESP: begin
               o_resp_stb <= 1'b1;
               state      <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Command fields held for the whole sequence
   always_ff @(posedge i_radio_clk) begin
      if (cmd_accept) begin
         op_q   <= i_cmd.opcode;
         addr_q <= i_cmd.addr;
         data_q <= i_cmd.data;
      end
   end

   always_comb begin
      o_set.stb  = set_stb_q;
      o_set.addr = addr_q;
      o_set.data = data_q;
   end

endmodule

// ==== rtl/timekeeper.sv ====
// Free-running 64-bit radio time.
// The time is staged as two words over the settings bus, then loaded at once
// or at the next rising PPS edge. The time of each PPS edge is latched.
`timescale 1ns/1ps

module timekeeper
   import radio_pkg::*;
(
   input  logic              i_radio_clk,
   input  logic              i_rst,
   input  set_bus_t          i_set,
   input  logic              i_pps,
   output logic [TIME_W-1:0] o_vita_time,
   output logic [TIME_W-1:0] o_vita_time_lastpps
);

   logic [SET_DATA_W-1:0] time_hi_q;
   logic [SET_DATA_W-1:0] time_lo_q;
   logic [TIME_W-1:0]     time_staged;
   logic                  pps_q;
   logic                  pps_edge;
   logic                  pps_pending;
   logic                  load_now;
   logic                  load_at_pps;

   assign time_staged = {time_hi_q, time_lo_q};
   assign pps_edge    = i_pps && !pps_q;
   assign load_now    = i_set.stb && (i_set.addr == SR_TIME_NOW);
   assign load_at_pps = i_set.stb && (i_set.addr == SR_TIME_PPS);

   //////////////////////////////
   // Staging and PPS arm
   //////////////////////////////
   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         time_hi_q   <= '0;
         time_lo_q   <= '0;
         pps_q       <= 1'b0;
         pps_pending <= 1'b0;
      end else begin
         pps_q <= i_pps;
         if (i_set.stb && (i_set.addr == SR_TIME_HI)) begin
            time_hi_q <= i_set.data;
         end
         if (i_set.stb && (i_set.addr == SR_TIME_LO)) begin
            time_lo_q <= i_set.data;
         end
         // A fresh arm wins over an edge seen on the same cycle
         if (load_at_pps) begin
            pps_pending <= 1'b1;
         end else if (pps_edge) begin
            pps_pending <= 1'b0;
         end
      end
   end

   //////////////////////////////
   // Counter and PPS latch
   //////////////////////////////
   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         o_vita_time         <= '0;
         o_vita_time_lastpps <= '0;
      end else begin
         if (load_now) begin
            o_vita_time <= time_staged;
         end else if (pps_edge && pps_pending) begin
            o_vita_time <= time_staged;
         end else begin
            o_vita_time <= o_vita_time + TIME_W'(1);
         end

         // Time as it stood just before the edge
         if (pps_edge) begin
            o_vita_time_lastpps <= o_vita_time;
         end
      end
   end

endmodule

// ==== rtl/radio_settings.sv ====
// Radio setting registers on the settings bus.
// Decodes loopback, test, readback select, misc outputs and codec idle,
// makes the DAC sync pulse and applies loopback to the receive word.
`timescale 1ns/1ps

module radio_settings
   import radio_pkg::*;
(
   input  logic                i_radio_clk,
   input  logic                i_rst,
   input  set_bus_t            i_set,
   input  logic [SAMPLE_W-1:0] i_rx,
   output logic [SAMPLE_W-1:0] o_tx,
   output logic [SAMPLE_W-1:0] o_rx_fe,
   output logic [31:0]         o_test,
   output rb_slot_e            o_rb_sel,
   output logic [MISC_W-1:0]   o_misc_outs,
   output logic                o_sync_dacs
);

   logic                loopback_q;
   logic [SAMPLE_W-1:0] codec_idle_q;

   //////////////////////////////
   // Register decode
   //////////////////////////////
   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         loopback_q   <= 1'b0;
         o_test       <= '0;
         o_rb_sel     <= RB_NONE;
         o_misc_outs  <= '0;
         codec_idle_q <= '0;
         o_sync_dacs  <= 1'b0;
      end else begin
         // Any write to the sync address fires whatever its data
         o_sync_dacs <= i_set.stb && (i_set.addr == SR_DACSYNC);

         if (i_set.stb) begin
            case (i_set.addr)
               SR_LOOPBACK: begin
                  loopback_q <= i_set.data[0];
               end
               SR_TEST: begin
                  o_test <= i_set.data;
               end
               SR_READBACK: begin
                  o_rb_sel <= rb_slot_e'(i_set.data[RB_SEL_W-1:0]);
               end
               SR_MISC_OUTS: begin
                  o_misc_outs <= i_set.data[MISC_W-1:0];
               end
               SR_CODEC_IDLE: begin
                  codec_idle_q <= i_set.data[SAMPLE_W-1:0];
               end
               default: begin
                  // Other addresses belong to the timekeeper
               end
            endcase
         end
      end
   end

   //////////////////////////////
   // Sample paths
   //////////////////////////////
   // No transmit chain, so the idle word always goes out
   assign o_tx = codec_idle_q;

   // Digital loopback TX to RX
   assign o_rx_fe = loopback_q ? o_tx : i_rx;

endmodule

// ==== rtl/readback_mux.sv ====
// Readback word selection for the command response.
// Picks one of the readback slots and holds it until the next capture.
`timescale 1ns/1ps

module readback_mux
   import radio_pkg::*;
#(
   parameter int unsigned RADIO_NUM = 0
) (
   input  logic                i_radio_clk,
   input  logic                i_rst,
   input  logic                i_capture,
   input  rb_slot_e            i_rb_sel,
   input  logic [TIME_W-1:0]   i_vita_time,
   input  logic [TIME_W-1:0]   i_vita_time_lastpps,
   input  logic [SAMPLE_W-1:0] i_rx_fe,
   input  logic [31:0]         i_test,
   input  logic [SAMPLE_W-1:0] i_tx,
   output rb_word_t            o_rb
);

   rb_word_t rb_next;

   always_comb begin
      case (i_rb_sel)
         RB_TIME:      rb_next = i_vita_time;
         RB_LASTPPS:   rb_next = i_vita_time_lastpps;
         RB_RX_TEST:   rb_next = {i_rx_fe, i_test};
         RB_TX_RX:     rb_next = {i_tx, i_rx_fe};
         RB_RADIO_NUM: rb_next = rb_word_t'(RADIO_NUM);
         // Slots 0 and 4 had SPI and GPIO behind them
         default:      rb_next = '0;
      endcase
   end

   always_ff @(posedge i_radio_clk) begin
      if (i_rst) begin
         o_rb <= '0;
      end else if (i_capture) begin
         o_rb <= rb_next;
      end
   end

endmodule

// ==== rtl/radio_core.sv ====
// Top level of the radio control plane in the radio clock domain.
// Commands come in on a strobe and each gets one readback word back.
`timescale 1ns/1ps

module radio_core
   import radio_pkg::*;
#(
   parameter int unsigned RADIO_NUM = 0
) (
   input  logic                i_radio_clk,
   input  logic                i_rst,
   input  logic                i_cmd_stb,
   input  cmd_t                i_cmd,
   input  logic [SAMPLE_W-1:0] i_rx,
   input  logic                i_pps,
   output logic                o_busy,
   output logic                o_resp_stb,
   output rb_word_t            o_resp,
   output logic [SAMPLE_W-1:0] o_tx,
   output logic [MISC_W-1:0]   o_misc_outs,
   output logic                o_sync_dacs
);

   set_bus_t            set_bus;
   logic                capture;
   rb_slot_e            rb_sel;
   logic [31:0]         test_word;
   logic [SAMPLE_W-1:0] rx_fe;
   logic [TIME_W-1:0]   vita_time;
   logic [TIME_W-1:0]   vita_time_lastpps;

   radio_ctrl_fsm u_radio_ctrl_fsm (
      .i_radio_clk (i_radio_clk),
      .i_rst       (i_rst),
      .i_cmd_stb   (i_cmd_stb),
      .i_cmd       (i_cmd),
      .o_set       (set_bus),
      .o_capture   (capture),
      .o_busy      (o_busy),
      .o_resp_stb  (o_resp_stb)
   );

   timekeeper u_timekeeper (
      .i_radio_clk         (i_radio_clk),
      .i_rst               (i_rst),
      .i_set               (set_bus),
      .i_pps               (i_pps),
      .o_vita_time         (vita_time),
      .o_vita_time_lastpps (vita_time_lastpps)
   );

   radio_settings u_radio_settings (
      .i_radio_clk (i_radio_clk),
      .i_rst       (i_rst),
      .i_set       (set_bus),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .o_rx_fe     (rx_fe),
      .o_test      (test_word),
      .o_rb_sel    (rb_sel),
      .o_misc_outs (o_misc_outs),
      .o_sync_dacs (o_sync_dacs)
   );

   readback_mux #(
      .RADIO_NUM (RADIO_NUM)
   ) u_readback_mux (
      .i_radio_clk         (i_radio_clk),
      .i_rst               (i_rst),
      .i_capture           (capture),
      .i_rb_sel            (rb_sel),
      .i_vita_time         (vita_time),
      .i_vita_time_lastpps (vita_time_lastpps),
      .i_rx_fe             (rx_fe),
      .i_test              (test_word),
      .i_tx                (o_tx),
      .o_rb                (o_resp)
   );

endmodule

// ==== bench/radio_core_checker.sv ====
// Protocol assertions for the command sequencer.
// Bound into every radio_ctrl_fsm; the testbench adds fail_count to its totals.
`timescale 1ns/1ps

module radio_core_checker
   import radio_pkg::*;
(
   input logic     i_radio_clk,
   input logic     i_rst,
   input logic     i_cmd_stb,
   input cmd_t     i_cmd,
   input set_bus_t i_set,
   input logic     i_busy,
   input logic     i_resp_stb
);

   int unsigned fail_count = 0;
   logic        accept;

   assign accept = i_cmd_stb && !i_busy;

   // Response strobe rises three edges after the accepting edge and at no other time
   a_resp_after_accept: assert property (@(posedge i_radio_clk) disable iff (i_rst)
      accept |-> ##4 i_resp_stb)
      else begin
         fail_count = fail_count + 1;
         $error("response strobe missing after accepted command");
      end

   a_resp_has_accept: assert property (@(posedge i_radio_clk) disable iff (i_rst)
      i_resp_stb |-> $past(accept, 4))
      else begin
         fail_count = fail_count + 1;
         $error("response strobe without accepted command");
      end

   a_set_single: assert property (@(posedge i_radio_clk) disable iff (i_rst)
      i_set.stb |=> !i_set.stb)
      else begin
         fail_count = fail_count + 1;
         $error("settings strobe held for two cycles");
      end

   // Only a write opens the settings bus
   a_set_write_only: assert property (@(posedge i_radio_clk) disable iff (i_rst)
      i_set.stb |-> $past(accept && (i_cmd.opcode == OP_WRITE), 2))
      else begin
         fail_count = fail_count + 1;
         $error("settings strobe without a write command");
      end

   a_idle_after_reset: assert property (@(posedge i_radio_clk)
      i_rst |=> !i_busy)
      else begin
         fail_count = fail_count + 1;
         $error("busy high right after reset");
      end

endmodule

bind radio_ctrl_fsm radio_core_checker u_ctrl_checker (
   .i_radio_clk (i_radio_clk),
   .i_rst       (i_rst),
   .i_cmd_stb   (i_cmd_stb),
   .i_cmd       (i_cmd),
   .i_set       (o_set),
   .i_busy      (o_busy),
   .i_resp_stb  (o_resp_stb)
);

// ==== bench/radio_core_tb.sv ====
// Testbench for radio_core. Drives commands on falling edges, keeps its own
// model of the registers and the time, and checks every readback word.
`timescale 1ns/1ps

module radio_core_tb
   import radio_pkg::*;
();

   localparam int RST_CYCLES = 8;
   localparam int NUM_CMDS   = 40;
   localparam int CMD_CYCLES = 5;
   localparam int GAP_CYCLES = 20;
   localparam int MAX_CYCLES = RST_CYCLES + NUM_CMDS * CMD_CYCLES + GAP_CYCLES + 50;

   logic                radio_clk = 1'b0;
   logic                rst;
   logic                cmd_stb;
   cmd_t                cmd;
   logic [SAMPLE_W-1:0] rx;
   logic                pps;
   logic                busy;
   logic                resp_stb;
   rb_word_t            resp;
   logic [SAMPLE_W-1:0] tx;
   logic [MISC_W-1:0]   misc_outs;
   logic                sync_dacs;

   // Register and time model
   logic [31:0]         m_test;
   logic [31:0]         m_codec_idle;
   logic [31:0]         m_hi;
   logic [31:0]         m_lo;
   logic [MISC_W-1:0]   m_misc;
   rb_slot_e            m_sel;
   logic                m_loop;
   logic                m_pps_pending;
   logic [TIME_W-1:0]   m_base;
   logic [TIME_W-1:0]   m_lastpps;
   int                  m_base_edge;

   integer              seed = 32'h6449_b794;
   rb_word_t            exp_q[$];
   int                  edge_cnt = 0;
   int                  cmd_cnt = 0;
   int                  resp_cnt = 0;
   int                  test_errors = 0;
   int                  errors = 0;
   int                  test_num = 0;

   radio_core #(
      .RADIO_NUM (3)
   ) u_radio_core (
      .i_radio_clk (radio_clk),
      .i_rst       (rst),
      .i_cmd_stb   (cmd_stb),
      .i_cmd       (cmd),
      .i_rx        (rx),
      .i_pps       (pps),
      .o_busy      (busy),
      .o_resp_stb  (resp_stb),
      .o_resp      (resp),
      .o_tx        (tx),
      .o_misc_outs (misc_outs),
      .o_sync_dacs (sync_dacs)
   );

   always #2 radio_clk = ~radio_clk;

   always @(posedge radio_clk) begin
      edge_cnt <= edge_cnt + 1;
   end

   always @(negedge radio_clk) begin
      if (edge_cnt > MAX_CYCLES) begin
         $display("Timeout after %0d cycles, a response never arrived", edge_cnt);
         $display("Checks failed");
         $finish;
      end
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////
   // Word captured at cap_edge holds the time from just after the edge before
   function automatic rb_word_t expected_rb(input logic [31:0] rx_in, input int cap_edge);
      logic [31:0] rx_fe;
      rx_fe = m_loop ? m_codec_idle : rx_in;
      case (m_sel)
         RB_TIME:      return m_base + TIME_W'(cap_edge - 1 - m_base_edge);
         RB_LASTPPS:   return m_lastpps;
         RB_RX_TEST:   return {rx_fe, m_test};
         RB_TX_RX:     return {m_codec_idle, rx_fe};
         RB_RADIO_NUM: return rb_word_t'(3);
         default:      return '0;
      endcase
   endfunction

   task automatic update_model(input cmd_op_e op, input logic [7:0] addr,
                               input logic [31:0] data, input int load_edge);
      if (op == OP_WRITE) begin
         case (addr)
            SR_LOOPBACK:   m_loop = data[0];
            SR_TEST:       m_test = data;
            SR_READBACK:   m_sel = rb_slot_e'(data[2:0]);
            SR_MISC_OUTS:  m_misc = data[7:0];
            SR_CODEC_IDLE: m_codec_idle = data;
            SR_TIME_HI:    m_hi = data;
            SR_TIME_LO:    m_lo = data;
            SR_TIME_NOW: begin
               m_base      = {m_hi, m_lo};
               m_base_edge = load_edge;
            end
            SR_TIME_PPS:   m_pps_pending = 1'b1;
            default: begin
            end
         endcase
      end
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////
   task automatic check_rb(input rb_word_t got, input rb_word_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: o_resp got %h expected %h", $time, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_misc(input logic [MISC_W-1:0] got, input logic [MISC_W-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: o_misc_outs got %h expected %h", $time, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_tx(input logic [SAMPLE_W-1:0] got, input logic [SAMPLE_W-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: o_tx got %h expected %h", $time, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_pulse(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: o_sync_dacs got %b expected %b", $time, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_busy(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: o_busy got %b expected %b", $time, got, exp);
         test_errors++;
      end
   endtask

   always @(negedge radio_clk) begin
      if (resp_stb) begin
         if (exp_q.size() == 0) begin
            $display("Response strobe at %0t ns with no command outstanding", $time);
            test_errors++;
         end else begin
            check_rb(resp, exp_q.pop_front());
         end
         resp_cnt++;
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   // Sends one command and watches busy and the sync pulse until its response is in
   task automatic do_cmd(input cmd_op_e op, input logic [7:0] addr, input logic [31:0] data);
      int   e0;
      int   pulse_edge;
      logic resp_seen;
      while (busy) begin
         @(negedge radio_clk);
      end
      e0         = edge_cnt + 1;
      pulse_edge = (op == OP_WRITE && addr == SR_DACSYNC) ? e0 + 2 : -1;
      cmd_stb    = 1'b1;
      cmd        = '{opcode: op, spare: '0, addr: addr, data: data};
      update_model(op, addr, data, e0 + 2);
      exp_q.push_back(expected_rb(rx, e0 + 3));
      cmd_cnt++;
      resp_seen = 1'b0;
      while (!resp_seen) begin
         @(negedge radio_clk);
         cmd_stb = 1'b0;
         check_busy(busy, edge_cnt < e0 + 3);
         check_pulse(sync_dacs, edge_cnt == pulse_edge);
         resp_seen = resp_stb;
      end
      // Compare process takes the response on that same falling edge
      @(negedge radio_clk);
   endtask

   // The DUT sees the rising PPS at the next clock edge
   task automatic pulse_pps();
      pps       = 1'b1;
      m_lastpps = m_base + TIME_W'(edge_cnt - m_base_edge);
      if (m_pps_pending) begin
         m_base        = {m_hi, m_lo};
         m_base_edge   = edge_cnt + 1;
         m_pps_pending = 1'b0;
      end
      repeat (3) @(negedge radio_clk);
      pps = 1'b0;
      @(negedge radio_clk);
   endtask

   task automatic end_test(input string name);
      test_num++;
      $display("Test %0d %s: %0d errors", test_num, name, test_errors);
      errors      = errors + test_errors;
      test_errors = 0;
   endtask

   initial begin
      int gap;
      rst           = 1'b1;
      cmd_stb       = 1'b0;
      cmd           = '0;
      rx            = '0;
      pps           = 1'b0;
      m_test        = '0;
      m_codec_idle  = '0;
      m_hi          = '0;
      m_lo          = '0;
      m_misc        = '0;
      m_sel         = RB_NONE;
      m_loop        = 1'b0;
      m_pps_pending = 1'b0;
      m_lastpps     = '0;
      m_base        = '0;
      repeat (RST_CYCLES) @(negedge radio_clk);
      rst         = 1'b0;
      m_base_edge = edge_cnt;

      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_RX_TEST));
      repeat (4) begin
         rx = $random(seed);
         do_cmd(OP_WRITE, SR_TEST, $random(seed));
         do_cmd(OP_WRITE, SR_MISC_OUTS, $random(seed));
         check_misc(misc_outs, m_misc);
         do_cmd(OP_READ, 8'd0, 32'd0);
      end
      end_test("test and misc registers");

      do_cmd(OP_WRITE, SR_CODEC_IDLE, $random(seed));
      check_tx(tx, m_codec_idle);
      rx = $random(seed);
      do_cmd(OP_READ, 8'd0, 32'd0);
      do_cmd(OP_WRITE, SR_LOOPBACK, 32'd1);
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_TX_RX));
      do_cmd(OP_WRITE, SR_CODEC_IDLE, $random(seed));
      check_tx(tx, m_codec_idle);
      do_cmd(OP_WRITE, SR_LOOPBACK, 32'd0);
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_RX_TEST));
      end_test("codec idle and loopback");

      do_cmd(OP_WRITE, SR_TIME_HI, $random(seed));
      do_cmd(OP_WRITE, SR_TIME_LO, $random(seed));
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_TIME));
      do_cmd(OP_WRITE, SR_TIME_NOW, 32'd0);
      repeat (3) begin
         gap = $random(seed) & 3;
         repeat (gap) @(negedge radio_clk);
         do_cmd(OP_READ, 8'd0, 32'd0);
      end
      end_test("time load now");

      do_cmd(OP_WRITE, SR_TIME_HI, $random(seed));
      do_cmd(OP_WRITE, SR_TIME_LO, $random(seed));
      do_cmd(OP_WRITE, SR_TIME_PPS, 32'd0);
      do_cmd(OP_READ, 8'd0, 32'd0);
      repeat (5) @(negedge radio_clk);
      pulse_pps();
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_LASTPPS));
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_TIME));
      do_cmd(OP_READ, 8'd0, 32'd0);
      end_test("time load at PPS");

      do_cmd(OP_WRITE, SR_DACSYNC, $random(seed));
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_RADIO_NUM));
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_NONE));
      do_cmd(OP_WRITE, SR_READBACK, 32'(RB_ZERO));
      do_cmd(OP_WRITE, SR_READBACK, 32'd7);
      do_cmd(OP_READ, 8'd0, 32'd0);
      end_test("DAC sync and fixed slots");

      errors = errors + int'(u_radio_core.u_radio_ctrl_fsm.u_ctrl_checker.fail_count);
      $display("Summary: %0d tests, %0d commands, %0d responses, %0d errors",
               test_num, cmd_cnt, resp_cnt, errors);
      if (errors == 0 && resp_cnt == cmd_cnt) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== radio_ctrl.f ====
rtl/radio_pkg.sv
rtl/radio_ctrl_fsm.sv
rtl/timekeeper.sv
rtl/radio_settings.sv
rtl/readback_mux.sv
rtl/radio_core.sv
bench/radio_core_checker.sv
bench/radio_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the radio control testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module radio_core_tb \
   -f radio_ctrl.f -o radio_core_sim \
   && ./obj_dir/radio_core_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "All checks passed" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
